// ==== verilog/squeeze_consts.svh ====
// Sizes and host address map of the squeeze layer
// Included by both packages and by any RTL file that uses a size
`ifndef SQUEEZE_CONSTS_SVH
`define SQUEEZE_CONSTS_SVH

// Output channels, one MAC lane each
`define SQ_LANES 4
// Input channels per pixel
`define SQ_CHIN 4'd8
// Feature map side, 16 pixels in total
`define SQ_WOUT 4
// Q2.14 data width
`define SQ_DW 16
// AXI4-Lite widths
`define SQ_AW 12
`define SQ_AXI_DW 32

// Host address map, byte addresses
`define SQ_ADDR_CTRL 12'h000
`define SQ_ADDR_STATUS 12'h004
`define SQ_IFM_BASE 12'h400
`define SQ_OFM_BASE 12'h800
`define SQ_IFM_WORDS (`SQ_CHIN * `SQ_WOUT * `SQ_WOUT)
`define SQ_OFM_WORDS (`SQ_LANES * `SQ_WOUT * `SQ_WOUT)

// AXI response codes
`define SQ_RESP_OKAY 2'b00
`define SQ_RESP_SLVERR 2'b10

`endif

// ==== verilog/squeeze_data_pkg.sv ====
// Fixed-point data types of the squeeze data path
// Q2.14 for pixels and weights, Q4.28 inside the MAC lanes
`include "squeeze_consts.svh"

package squeeze_data_pkg;

	// Q2.14 pixel or weight
	typedef logic signed [`SQ_DW-1:0] pix_t;

	// Q4.28 accumulator, product of two Q2.14 words
	typedef logic signed [2*`SQ_DW-1:0] acc_t;

	// One word per output channel
	typedef pix_t [`SQ_LANES-1:0] lane_pix_t;
	typedef acc_t [`SQ_LANES-1:0] lane_acc_t;

	// Input channel index, also the weight ROM address
	typedef logic [$clog2(`SQ_CHIN)-1:0] wadr_t;

	// Output pixel index
	typedef logic [$clog2(`SQ_WOUT*`SQ_WOUT)-1:0] pixidx_t;

endpackage

// ==== verilog/squeeze_ctrl_pkg.sv ====
// Control and bus types: the feeder FSM states, the AXI4-Lite channels
// and the links between the host slave and the feature-map memories
`include "squeeze_consts.svh"

package squeeze_ctrl_pkg;

	// Input RAM sequencer
	typedef enum logic [1:0] {
		seq_idle,
		seq_run,
		seq_drain
	} seq_state_t;

	typedef logic [`SQ_AW-1:0] axi_addr_t;
	typedef logic [`SQ_AXI_DW-1:0] axi_data_t;
	typedef logic [$clog2(`SQ_IFM_WORDS)-1:0] ifm_addr_t;
	typedef logic [$clog2(`SQ_OFM_WORDS)-1:0] ofm_addr_t;

	// Host to slave, all five channels
	typedef struct packed {
		axi_addr_t awaddr;
		logic awvalid;
		axi_data_t wdata;
		logic [`SQ_AXI_DW/8-1:0] wstrb;
		logic wvalid;
		logic bready;
		axi_addr_t araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// Slave to host
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		axi_data_t rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

	// Input RAM write strobe
	typedef struct packed {
		logic valid;
		ifm_addr_t addr;
		squeeze_data_pkg::pix_t data;
	} ifm_wr_t;

	// Output RAM read request
	typedef struct packed {
		ofm_addr_t addr;
		logic re;
	} ofm_rd_t;

endpackage

// ==== verilog/squeeze_weight_rom.sv ====
// Weight and bias tables of the squeeze layer, built from an arithmetic rule
// One registered read returns the weights of all lanes for one input channel
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_weight_rom (
	input  logic clk,
	input  squeeze_data_pkg::wadr_t addr,
	output squeeze_data_pkg::lane_pix_t weights,
	output squeeze_data_pkg::lane_acc_t bias
);

	// 256 * (k - 32), k spread over 0..63
	function automatic squeeze_data_pkg::pix_t weight_rule(int lane, int chan);
		int k;
		k = ((lane * `SQ_CHIN + chan) * 37) % 64;
		return squeeze_data_pkg::pix_t'(256 * (k - 32));
	endfunction

	// Q2.14 bias moved up to Q4.28
	function automatic squeeze_data_pkg::acc_t bias_rule(int lane);
		return squeeze_data_pkg::acc_t'((4096 * lane - 6144) * (1 << 14));
	endfunction

	// Registered read, all lanes at once
	always_ff @(posedge clk) begin
		for (int l = 0; l < `SQ_LANES; l++) begin
			weights[l] <= weight_rule(l, int'(addr));
		end
	end

	// Bias per lane is constant
	for (genvar l = 0; l < `SQ_LANES; l++) begin : g_bias
		assign bias[l] = bias_rule(l);
	end

endmodule

// ==== verilog/squeeze_mac.sv ====
// One multiply-accumulate lane of the squeeze engine
// Sum of one pixel's channels is released on the clear pulse
`timescale 1ns/1ps

module squeeze_mac (
	input  logic clk,
	input  logic rst_n,
	input  logic layer_en,
	input  logic clr,
	input  squeeze_data_pkg::pix_t pix,
	input  squeeze_data_pkg::pix_t ker,
	output squeeze_data_pkg::acc_t mul_out
);

	squeeze_data_pkg::acc_t prod;
	squeeze_data_pkg::acc_t acc;

	// Q2.14 x Q2.14 gives Q4.28, signed on both sides
	assign prod = pix * ker;

	// Clear restarts with the first product of the next pixel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (clr) begin
			acc <= layer_en ? prod : '0;
		end else if (layer_en) begin
			// wraps at 32 bits
			acc <= acc + prod;
		end
	end

	// Finished sum, held until the next clear
	always_ff @(posedge clk) begin
		if (clr) begin
			mul_out <= acc;
		end
	end

endmodule

// ==== verilog/squeeze_layer.sv ====
// 1x1 squeeze convolution engine: channels of each pixel stream in on
// layer_en, SQ_LANES lanes accumulate, then bias, ReLU and Q2.14 truncation
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_layer (
	input  logic clk,
	input  logic rst_n,
	input  logic layer_en,
	input  squeeze_data_pkg::pix_t ifm,
	output logic sample,
	output logic finish,
	output squeeze_data_pkg::lane_pix_t ofm,
	output squeeze_data_pkg::pixidx_t pix_idx
);

	squeeze_data_pkg::wadr_t chan_cnt;
	squeeze_data_pkg::wadr_t rom_addr;
	squeeze_data_pkg::lane_pix_t weights;
	squeeze_data_pkg::lane_acc_t bias;
	squeeze_data_pkg::lane_acc_t mul_out;
	squeeze_data_pkg::pixidx_t pix_cnt;
	logic layer_en_d;
	logic layer_start;
	logic rom_clr;
	logic clr_pulse;
	logic clr_d;

	// Clamp negatives, else keep bits 28..14 with a zero sign
	function automatic squeeze_data_pkg::pix_t relu_trunc(squeeze_data_pkg::acc_t v);
		if (v[2*`SQ_DW-1]) begin
			return '0;
		end
		return {1'b0, v[2*`SQ_DW-4 -: `SQ_DW-1]};
	endfunction

	//////////////////////////////////////////////////
	// Weight addressing and clear pulse
	//////////////////////////////////////////////////

	// First enable of a layer always starts at channel 0
	assign layer_start = layer_en && !layer_en_d;
	assign rom_addr = layer_start ? '0 : chan_cnt;

	squeeze_weight_rom i_rom (
		.clk(clk),
		.addr(rom_addr),
		.weights(weights),
		.bias(bias)
	);

	// Weights come out of the ROM register together with ifm and layer_en_d
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			chan_cnt <= '0;
			layer_en_d <= 1'b0;
			rom_clr <= 1'b0;
			clr_pulse <= 1'b0;
			clr_d <= 1'b0;
		end else begin
			layer_en_d <= layer_en;
			if (layer_en) begin
				chan_cnt <= rom_addr + squeeze_data_pkg::wadr_t'(1);
			end
			// Last channel of a pixel seen
			rom_clr <= layer_en && (rom_addr == squeeze_data_pkg::wadr_t'(`SQ_CHIN - 1));
			// Lines up with the last product entering the lanes
			clr_pulse <= rom_clr;
			// Lane sums valid in this cycle
			clr_d <= clr_pulse;
		end
	end

	//////////////////////////////////////////////////
	// MAC lanes
	//////////////////////////////////////////////////

	for (genvar l = 0; l < `SQ_LANES; l++) begin : g_lane
		squeeze_mac i_mac (
			.clk(clk),
			.rst_n(rst_n),
			.layer_en(layer_en_d),
			.clr(clr_pulse),
			.pix(ifm),
			.ker(weights[l]),
			.mul_out(mul_out[l])
		);
	end

	//////////////////////////////////////////////////
	// Bias, ReLU, truncation and layer end
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (clr_d) begin
			for (int l = 0; l < `SQ_LANES; l++) begin
				ofm[l] <= relu_trunc(mul_out[l] + bias[l]);
			end
		end
	end

	// sample comes with ofm, one pixel per pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sample <= 1'b0;
			finish <= 1'b0;
			pix_cnt <= '0;
		end else begin
			sample <= clr_d;
			// One pulse after the last pixel is out
			finish <= sample && (pix_cnt == squeeze_data_pkg::pixidx_t'(`SQ_WOUT*`SQ_WOUT - 1));
			if (layer_start) begin
				pix_cnt <= '0;
			end else if (sample) begin
				pix_cnt <= pix_cnt + squeeze_data_pkg::pixidx_t'(1);
			end
		end
	end

	assign pix_idx = pix_cnt;

endmodule

// ==== verilog/squeeze_fmap_mem.sv ====
// Input and output feature-map RAMs of the squeeze layer
// Feeds the engine one channel per cycle after start, stores each sampled pixel
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_fmap_mem (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  squeeze_ctrl_pkg::ifm_wr_t ifm_wr,
	input  squeeze_ctrl_pkg::ofm_rd_t ofm_rd,
	output squeeze_data_pkg::pix_t ofm_rdata,
	output logic layer_en,
	output squeeze_data_pkg::pix_t ifm,
	input  logic sample,
	input  squeeze_data_pkg::lane_pix_t ofm,
	input  squeeze_data_pkg::pixidx_t pix_idx
);

	squeeze_data_pkg::pix_t ifm_ram [`SQ_IFM_WORDS];
	// One row per pixel, one word per lane
	squeeze_data_pkg::lane_pix_t ofm_ram [`SQ_WOUT*`SQ_WOUT];
	squeeze_ctrl_pkg::seq_state_t state;
	squeeze_ctrl_pkg::ifm_addr_t rd_cnt;
	squeeze_data_pkg::pixidx_t rd_row;
	logic [$clog2(`SQ_LANES)-1:0] rd_lane;

	//////////////////////////////////////////////////
	// Input RAM and feeder
	//////////////////////////////////////////////////

	// Host writes, only while idle
	always_ff @(posedge clk) begin
		if (ifm_wr.valid) begin
			ifm_ram[ifm_wr.addr] <= ifm_wr.data;
		end
	end

	// Feeder FSM, 128 run cycles per layer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= squeeze_ctrl_pkg::seq_idle;
			rd_cnt <= '0;
		end else begin
			case (state)
				squeeze_ctrl_pkg::seq_idle: begin
					rd_cnt <= '0;
					if (start) begin
						state <= squeeze_ctrl_pkg::seq_run;
					end
				end
				squeeze_ctrl_pkg::seq_run: begin
					rd_cnt <= rd_cnt + squeeze_ctrl_pkg::ifm_addr_t'(1);
					if (rd_cnt == squeeze_ctrl_pkg::ifm_addr_t'(`SQ_IFM_WORDS - 1)) begin
						state <= squeeze_ctrl_pkg::seq_drain;
					end
				end
				// Last word leaves the read register
				squeeze_ctrl_pkg::seq_drain: state <= squeeze_ctrl_pkg::seq_idle;
				default: state <= squeeze_ctrl_pkg::seq_idle;
			endcase
		end
	end

	assign layer_en = (state == squeeze_ctrl_pkg::seq_run);

	// Synchronous read, one cycle behind layer_en
	always_ff @(posedge clk) begin
		if (layer_en) begin
			ifm <= ifm_ram[rd_cnt];
		end
	end

	//////////////////////////////////////////////////
	// Output RAM
	//////////////////////////////////////////////////

	// All lanes of one pixel in one write
	always_ff @(posedge clk) begin
		if (sample) begin
			ofm_ram[pix_idx] <= ofm;
		end
	end

	// Word index is pixel * lanes + lane
	assign rd_lane = ofm_rd.addr[$clog2(`SQ_LANES)-1:0];
	assign rd_row = ofm_rd.addr[$clog2(`SQ_LANES) +: $bits(squeeze_data_pkg::pixidx_t)];

	// Host read, one cycle latency
	always_ff @(posedge clk) begin
		if (ofm_rd.re) begin
			ofm_rdata <= ofm_ram[rd_row][rd_lane];
		end
	end

endmodule

// ==== verilog/squeeze_axil_regs.sv ====
// AXI4-Lite slave of the squeeze layer: control/status registers, input map
// writes and output map reads, with busy/done kept across a layer run
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_axil_regs (
	input  logic clk,
	input  logic rst_n,
	input  squeeze_ctrl_pkg::axil_req_t req,
	output squeeze_ctrl_pkg::axil_rsp_t rsp,
	output logic start,
	input  logic finish,
	output squeeze_ctrl_pkg::ifm_wr_t ifm_wr,
	output squeeze_ctrl_pkg::ofm_rd_t ofm_rd,
	input  squeeze_data_pkg::pix_t ofm_rdata
);

	logic aw_ctrl, aw_status, aw_ifm, aw_ofm, aw_ok;
	logic ar_ctrl, ar_status, ar_ifm, ar_ofm, ar_ok;
	logic wr_hs, rd_hs, wr_lanes;
	logic awready, wready, bvalid, arready, rvalid, rd_wait;
	logic [1:0] bresp, rresp;
	squeeze_ctrl_pkg::axi_data_t rdata;
	logic busy, done;
	logic ifm_we;
	squeeze_ctrl_pkg::ifm_addr_t ifm_addr;
	squeeze_data_pkg::pix_t ifm_data;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	assign aw_ctrl = (req.awaddr == `SQ_ADDR_CTRL);
	assign aw_status = (req.awaddr == `SQ_ADDR_STATUS);
	assign aw_ifm = (req.awaddr >= `SQ_IFM_BASE) &&
		(req.awaddr < `SQ_IFM_BASE + 4 * `SQ_IFM_WORDS);
	assign aw_ofm = (req.awaddr >= `SQ_OFM_BASE) &&
		(req.awaddr < `SQ_OFM_BASE + 4 * `SQ_OFM_WORDS);
	assign aw_ok = aw_ctrl || aw_status || aw_ifm || aw_ofm;

	assign ar_ctrl = (req.araddr == `SQ_ADDR_CTRL);
	assign ar_status = (req.araddr == `SQ_ADDR_STATUS);
	assign ar_ifm = (req.araddr >= `SQ_IFM_BASE) &&
		(req.araddr < `SQ_IFM_BASE + 4 * `SQ_IFM_WORDS);
	assign ar_ofm = (req.araddr >= `SQ_OFM_BASE) &&
		(req.araddr < `SQ_OFM_BASE + 4 * `SQ_OFM_WORDS);
	assign ar_ok = ar_ctrl || ar_status || ar_ifm || ar_ofm;

	// Low half carries all the data
	assign wr_lanes = |req.wstrb[1:0];

	//////////////////////////////////////////////////
	// Write channel
	//////////////////////////////////////////////////

	assign wr_hs = awready && wready && req.awvalid && req.wvalid;

	// AW and W taken together, one beat in flight
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (bvalid && req.bready) begin
				bvalid <= 1'b0;
			end
			if (wr_hs) begin
				awready <= 1'b0;
				wready <= 1'b0;
				bvalid <= 1'b1;
			end else if (!awready && !bvalid && req.awvalid && req.wvalid) begin
				awready <= 1'b1;
				wready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bresp <= aw_ok ? `SQ_RESP_OKAY : `SQ_RESP_SLVERR;
		end
	end

	// Start only from idle, finish ends the run
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			ifm_we <= 1'b0;
		end else begin
			start <= 1'b0;
			// Input map frozen while the layer runs
			ifm_we <= wr_hs && aw_ifm && wr_lanes && !busy;
			if (wr_hs && aw_ctrl && wr_lanes && req.wdata[0] && !busy) begin
				start <= 1'b1;
				busy <= 1'b1;
				done <= 1'b0;
			end else if (finish) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// Base is aligned, word index is the low address bits
	always_ff @(posedge clk) begin
		if (wr_hs) begin
			ifm_addr <= req.awaddr[2 +: $bits(squeeze_ctrl_pkg::ifm_addr_t)];
			ifm_data <= req.wdata[`SQ_DW-1:0];
		end
	end

	assign ifm_wr = '{valid: ifm_we, addr: ifm_addr, data: ifm_data};

	//////////////////////////////////////////////////
	// Read channel
	//////////////////////////////////////////////////

	assign rd_hs = arready && req.arvalid;

	// Output RAM read goes out on the AR handshake
	assign ofm_rd = '{
		addr: req.araddr[2 +: $bits(squeeze_ctrl_pkg::ofm_addr_t)],
		re: rd_hs && ar_ofm
	};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rd_wait <= 1'b0;
		end else begin
			if (rvalid && req.rready) begin
				rvalid <= 1'b0;
			end
			if (rd_hs) begin
				arready <= 1'b0;
				// RAM data one cycle later
				if (ar_ofm) begin
					rd_wait <= 1'b1;
				end else begin
					rvalid <= 1'b1;
				end
			end else if (!arready && !rvalid && !rd_wait && req.arvalid) begin
				arready <= 1'b1;
			end
			if (rd_wait) begin
				rd_wait <= 1'b0;
				rvalid <= 1'b1;
			end
		end
	end

	// Control and input map read back as zero
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rresp <= ar_ok ? `SQ_RESP_OKAY : `SQ_RESP_SLVERR;
			rdata <= ar_status ? {{(`SQ_AXI_DW-2){1'b0}}, done, busy} : '0;
		end else if (rd_wait) begin
			rdata <= {{(`SQ_AXI_DW-`SQ_DW){1'b0}}, ofm_rdata};
		end
	end

	assign rsp = '{
		awready: awready,
		wready: wready,
		bresp: bresp,
		bvalid: bvalid,
		arready: arready,
		rdata: rdata,
		rresp: rresp,
		rvalid: rvalid
	};

endmodule

// ==== verilog/squeeze_top.sv ====
// Top level of the squeeze layer accelerator
// Host loads the input map, starts the layer and reads results over AXI4-Lite
`timescale 1ns/1ps

module squeeze_top (
	input  logic clk,
	input  logic rst_n,
	input  squeeze_ctrl_pkg::axil_req_t axil_req,
	output squeeze_ctrl_pkg::axil_rsp_t axil_rsp
);

	// Slave to memories
	logic start;
	logic finish;
	squeeze_ctrl_pkg::ifm_wr_t ifm_wr;
	squeeze_ctrl_pkg::ofm_rd_t ofm_rd;
	squeeze_data_pkg::pix_t ofm_rdata;

	// Memories to engine and back
	logic layer_en;
	logic sample;
	squeeze_data_pkg::pix_t ifm;
	squeeze_data_pkg::lane_pix_t ofm;
	squeeze_data_pkg::pixidx_t pix_idx;

	squeeze_axil_regs i_regs (
		.clk(clk),
		.rst_n(rst_n),
		.req(axil_req),
		.rsp(axil_rsp),
		.start(start),
		.finish(finish),
		.ifm_wr(ifm_wr),
		.ofm_rd(ofm_rd),
		.ofm_rdata(ofm_rdata)
	);

	squeeze_fmap_mem i_mem (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.ifm_wr(ifm_wr),
		.ofm_rd(ofm_rd),
		.ofm_rdata(ofm_rdata),
		.layer_en(layer_en),
		.ifm(ifm),
		.sample(sample),
		.ofm(ofm),
		.pix_idx(pix_idx)
	);

	squeeze_layer i_layer (
		.clk(clk),
		.rst_n(rst_n),
		.layer_en(layer_en),
		.ifm(ifm),
		.sample(sample),
		.finish(finish),
		.ofm(ofm),
		.pix_idx(pix_idx)
	);

endmodule

// ==== verif/squeeze_tb_sva.sv ====
// Assertions on the squeeze engine output timing and the AXI4-Lite responses
// Bound into squeeze_layer and squeeze_axil_regs, unused inputs tied low
`timescale 1ns/1ps

module squeeze_tb_sva (
	input logic clk,
	input logic rst_n,
	input logic clr_d,
	input logic sample,
	input logic finish,
	input logic layer_en,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready
);

	// Read by the testbench at the end of the run
	int fail_count = 0;

	// Lane sums latched, sample one cycle later
	assert property (@(posedge clk) disable iff (!rst_n) clr_d |=> sample)
	else begin
		$error("sample did not follow the lane clear by one cycle");
		fail_count++;
	end

	// One pixel per 8 enable cycles
	assert property (@(posedge clk) disable iff (!rst_n) sample |=> !sample [*7])
	else begin
		$error("sample pulses closer than one pixel apart");
		fail_count++;
	end

	// End of layer only after the feeder stopped
	assert property (@(posedge clk) disable iff (!rst_n) !(finish && layer_en))
	else begin
		$error("finish high while layer_en is high");
		fail_count++;
	end

	// Responses held until accepted
	assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
	else begin
		$error("bvalid dropped before bready");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
	else begin
		$error("rvalid dropped before rready");
		fail_count++;
	end

endmodule

bind squeeze_layer squeeze_tb_sva i_sva (
	.clk(clk),
	.rst_n(rst_n),
	.clr_d(clr_d),
	.sample(sample),
	.finish(finish),
	.layer_en(layer_en),
	.bvalid(1'b0),
	.bready(1'b0),
	.rvalid(1'b0),
	.rready(1'b0)
);

bind squeeze_axil_regs squeeze_tb_sva i_sva (
	.clk(clk),
	.rst_n(rst_n),
	.clr_d(1'b0),
	.sample(1'b0),
	.finish(1'b0),
	.layer_en(1'b0),
	.bvalid(bvalid),
	.bready(req.bready),
	.rvalid(rvalid),
	.rready(req.rready)
);

// ==== verif/squeeze_tb.sv ====
// Testbench of the squeeze layer: loads input maps over AXI4-Lite, runs the layer
// and checks every output word against a fixed-point model of the layer
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_tb;

	localparam int NTESTS = 4;
	localparam int HS_LIMIT = 20;
	localparam int POLL_LIMIT = 200;

	logic clk;
	logic rst_n;
	squeeze_ctrl_pkg::axil_req_t axil_req;
	squeeze_ctrl_pkg::axil_rsp_t axil_rsp;

	// Test table: name, fill mode, seed, extra start while busy
	// Fill mode 0 zero map, 1 random map, 2 unmapped accesses only
	// Seed 0 keeps the generator running from the previous test
	string tbl_name [NTESTS];
	int tbl_mode [NTESTS];
	logic [31:0] tbl_seed [NTESTS];
	logic tbl_restart [NTESTS];

	// Model of the input map and the expected output words
	shortint ifm_model [`SQ_IFM_WORDS];
	logic [31:0] ofm_exp [`SQ_OFM_WORDS];
	logic [31:0] rng;
	string cur_name;
	int test_errors;
	int passed;
	int failed;

	squeeze_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// 256 * (k - 32), k = ((lane * 8 + chan) * 37) mod 64
	function automatic int weight_of(input int lane, input int chan);
		int k;
		k = ((lane * 8 + chan) * 37) % 64;
		return 256 * (k - 32);
	endfunction

	// Q2.14 bias in Q4.28
	function automatic int bias_of(input int lane);
		return (4096 * lane - 6144) * 16384;
	endfunction

	// Sum wraps at 32 bits, then ReLU and bits 28..14
	function automatic void build_expected();
		int acc;
		for (int p = 0; p < `SQ_WOUT * `SQ_WOUT; p++) begin
			for (int l = 0; l < `SQ_LANES; l++) begin
				acc = bias_of(l);
				for (int c = 0; c < 8; c++) begin
					acc += int'(ifm_model[p * 8 + c]) * weight_of(l, c);
				end
				ofm_exp[p * `SQ_LANES + l] = (acc < 0) ? 32'h0 : (acc >> 14) & 32'h7fff;
			end
		end
	endfunction

	//////////////////////////////////////////////////
	// Checks and AXI4-Lite host tasks
	//////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout in test %s while waiting for %s", cur_name, what);
		$display("Some tests failed");
		$finish;
	endtask

	// AW and W together; ready seen on a falling edge means handshake next
	// bready comes one cycle after bvalid, so the response has to wait
	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int cnt;
		@(negedge clk);
		axil_req.awaddr = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = 4'hf;
		axil_req.wvalid = 1'b1;
		axil_req.bready = 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!(axil_rsp.awready && axil_rsp.wready) && cnt < HS_LIMIT);
		if (!(axil_rsp.awready && axil_rsp.wready)) begin
			stop_on_timeout("awready and wready");
		end
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		cnt = 0;
		while (!axil_rsp.bvalid && cnt < HS_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (!axil_rsp.bvalid) begin
			stop_on_timeout("bvalid");
		end
		resp = axil_rsp.bresp;
		@(negedge clk);
		axil_req.bready = 1'b1;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	// rready comes one cycle after rvalid
	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int cnt;
		@(negedge clk);
		axil_req.araddr = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready = 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!axil_rsp.arready && cnt < HS_LIMIT);
		if (!axil_rsp.arready) begin
			stop_on_timeout("arready");
		end
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		// Output RAM reads take one more cycle
		cnt = 0;
		while (!axil_rsp.rvalid && cnt < HS_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (!axil_rsp.rvalid) begin
			stop_on_timeout("rvalid");
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(negedge clk);
		axil_req.rready = 1'b1;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	task automatic check_outputs();
		logic [31:0] data;
		logic [1:0] resp;
		for (int i = 0; i < `SQ_OFM_WORDS; i++) begin
			axi_read(`SQ_OFM_BASE + 12'(4 * i), data, resp);
			check_value($sformatf("ofm word %0d", i), ofm_exp[i], data);
			check_value("ofm read response", `SQ_RESP_OKAY, resp);
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequences
	//////////////////////////////////////////////////

	task automatic run_layer(input int mode, input logic restart);
		logic [31:0] data;
		logic [1:0] resp;
		int polls;
		for (int w = 0; w < `SQ_IFM_WORDS; w++) begin
			if (mode == 1) begin
				rng = lcg_next(rng);
				ifm_model[w] = shortint'(rng[31:16]);
			end else begin
				ifm_model[w] = 0;
			end
			axi_write(`SQ_IFM_BASE + 12'(4 * w), {16'h0, ifm_model[w]}, resp);
			check_value("ifm write response", `SQ_RESP_OKAY, resp);
		end
		build_expected();
		axi_write(`SQ_ADDR_CTRL, 32'h1, resp);
		check_value("start write response", `SQ_RESP_OKAY, resp);
		// Busy set, done of the earlier run cleared
		axi_read(`SQ_ADDR_STATUS, data, resp);
		check_value("status after start", 32'h1, data);
		if (restart) begin
			axi_write(`SQ_ADDR_CTRL, 32'h1, resp);
			check_value("start while busy response", `SQ_RESP_OKAY, resp);
			// Last input word, read late in the run, must stay as it was
			axi_write(`SQ_IFM_BASE + 12'h1fc, 32'h7fff, resp);
			check_value("ifm write while busy response", `SQ_RESP_OKAY, resp);
		end
		polls = 0;
		do begin
			axi_read(`SQ_ADDR_STATUS, data, resp);
			polls++;
		end while (!data[1] && polls < POLL_LIMIT);
		if (!data[1]) begin
			stop_on_timeout("done in the status register");
		end
		check_value("status at end", 32'h2, data);
		check_outputs();
	endtask

	task automatic unmapped_access();
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(12'hc00, data, resp);
		check_value("unmapped read response", `SQ_RESP_SLVERR, resp);
		axi_write(12'h008, 32'h1, resp);
		check_value("unmapped write response", `SQ_RESP_SLVERR, resp);
		axi_write(12'hc00, 32'h1, resp);
		check_value("unmapped write response", `SQ_RESP_SLVERR, resp);
		// No start, last results untouched
		axi_read(`SQ_ADDR_STATUS, data, resp);
		check_value("status after unmapped writes", 32'h2, data);
		check_value("status read response", `SQ_RESP_OKAY, resp);
		check_outputs();
	endtask

	initial begin
		int sva_fails;
		tbl_name[0] = "random_map";
		tbl_mode[0] = 1;
		tbl_seed[0] = 32'h9db1;
		tbl_restart[0] = 1'b1;
		tbl_name[1] = "zero_map";
		tbl_mode[1] = 0;
		tbl_seed[1] = 32'h0;
		tbl_restart[1] = 1'b0;
		tbl_name[2] = "rerun_map";
		tbl_mode[2] = 1;
		tbl_seed[2] = 32'h0;
		tbl_restart[2] = 1'b0;
		tbl_name[3] = "unmapped_bus";
		tbl_mode[3] = 2;
		tbl_seed[3] = 32'h0;
		tbl_restart[3] = 1'b0;
		axil_req = '0;
		rst_n = 1'b0;
		rng = 32'h9db1;
		passed = 0;
		failed = 0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		for (int t = 0; t < NTESTS; t++) begin
			cur_name = tbl_name[t];
			test_errors = 0;
			if (tbl_seed[t] != 32'h0) begin
				rng = tbl_seed[t];
			end
			if (tbl_mode[t] == 2) begin
				unmapped_access();
			end else begin
				run_layer(tbl_mode[t], tbl_restart[t]);
			end
			if (test_errors == 0) begin
				$display("test %s ok", cur_name);
				passed++;
			end else begin
				$display("test %s failed with %0d errors", cur_name, test_errors);
				failed++;
			end
		end
		sva_fails = i_dut.i_layer.i_sva.fail_count + i_dut.i_regs.i_sva.fail_count;
		$display("%0d tests: %0d ok, %0d with errors, %0d assertion failures",
			NTESTS, passed, failed, sva_fails);
		if (failed == 0 && sva_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/squeeze_data_pkg.sv
verilog/squeeze_ctrl_pkg.sv
verilog/squeeze_weight_rom.sv
verilog/squeeze_mac.sv
verilog/squeeze_layer.sv
verilog/squeeze_fmap_mem.sv
verilog/squeeze_axil_regs.sv
verilog/squeeze_top.sv
verif/squeeze_tb_sva.sv
verif/squeeze_tb.sv
